/* vlog.f */
+incdir+.
cp0_pkg.sv
cp0_write_mask.sv
cp0_timer.sv
cp0_exc_ctrl.sv
cp0_tlb_regs.sv
cp0.sv
tb_cp0.sv

/* Bender.yml */
package:
  name: cp0

sources:
  - files:
      - cp0_pkg.sv
      - cp0_write_mask.sv
      - cp0_timer.sv
      - cp0_exc_ctrl.sv
      - cp0_tlb_regs.sv
      - cp0.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cp0.sv

/* tb_cp0_vectors.svh */
`ifndef TB_CP0_VECTORS_SVH
`define TB_CP0_VECTORS_SVH

typedef enum logic [2:0] {
	op_write, op_read, op_except, op_eret, op_tlbr, op_tlbp, op_tlbwr, op_idle
} op_e;

typedef enum logic [3:0] {
	chk_none, chk_rdata, chk_tlb_wentry, chk_exc_level, chk_epc,
	chk_timer_int, chk_user_mode, chk_kseg0, chk_asid, chk_ebase
} chk_e;

typedef struct packed {
	op_e         op;
	reg_addr_t   addr;
	reg_sel_t    sel;
	word_t       data; // write data, probe result, or the AND filter of a random row
	word_t       pc;
	word_t       extra;
	exc_code_t   code;
	logic        ds;
	logic        rnd;
	tlb_entry_t  entry;
	logic [85:0] expected;
	chk_e        chk;
} row_t;

row_t rows[$];

// each step gives op, register number, select, data, output to compare and expected value
task automatic build_table();
	tlb_entry_t entry;
	entry = {19'h2_468a, 8'h5c, 24'h12_3456, 3'd3, 1'b1, 1'b1, 24'h65_4321, 3'd2, 1'b0,
		1'b1, 1'b1};
	// ------------------------------
	step(op_read, reg_status, 3'd0, '0, chk_rdata, 32'h1040_0000);
	step(op_read, reg_random, 3'd0, '0, chk_rdata, tlb_entries_num - 1);
	step(op_read, reg_ebase, 3'd1, '0, chk_rdata, 32'h8000_0000);
	step(op_idle, 5'd0, 3'd0, '0, chk_ebase, 32'h8000_0000);
	step(op_read, reg_prid, 3'd0, '0, chk_rdata, prid_value);
	step(op_read, reg_config1, 3'd1, '0, chk_rdata, config1_value);
	step(op_idle, 5'd0, 3'd0, '0, chk_exc_level, exc_normal);
	step(op_idle, 5'd0, 3'd0, '0, chk_timer_int, 1'b0);
	// ------------------------------
	random_step(op_write, reg_index, 3'd0, 32'hffff_ffff);
	random_step(op_read, reg_index, 3'd0, '0);
	random_step(op_write, reg_entry_lo0, 3'd0, 32'hffff_ffff);
	random_step(op_read, reg_entry_lo0, 3'd0, '0);
	random_step(op_write, reg_context, 3'd0, 32'hffff_ffff);
	random_step(op_read, reg_context, 3'd0, '0);
	random_step(op_write, reg_status, 3'd0, 32'hffff_fff9); // keeps EXL and ERL clear
	random_step(op_read, reg_status, 3'd0, '0);
	random_step(op_write, reg_cause, 3'd0, 32'hffff_ffff);
	random_step(op_read, reg_cause, 3'd0, '0);
	random_step(op_write, reg_ebase, 3'd1, 32'hffff_ffff);
	random_step(op_read, reg_ebase, 3'd1, '0);
	step(op_write, reg_ebase, 3'd1, 32'hffff_ffff, chk_ebase, 32'hbfff_f000);
	step(op_write, reg_status, 3'd0, 32'h1040_0000, chk_none, '0);
	step(op_write, reg_cause, 3'd0, 32'h0, chk_none, '0);
	step(op_write, reg_prid, 3'd0, 32'hdead_beef, chk_none, '0);
	step(op_read, reg_prid, 3'd0, '0, chk_rdata, prid_value);
	step(op_read, reg_status, 3'd2, '0, chk_rdata, 32'h0);
	step(op_read, reg_count, 3'd1, '0, chk_rdata, 32'h0);
	// ------------------------------
	step(op_write, reg_count, 3'd0, 32'd100, chk_none, '0);
	step(op_idle, 5'd0, 3'd0, '0, chk_none, '0);
	step(op_idle, 5'd0, 3'd0, '0, chk_none, '0);
	step(op_read, reg_count, 3'd0, '0, chk_rdata, 32'd103);
	step(op_write, reg_compare, 3'd0, 32'd109, chk_none, '0); // count is 103 in this cycle
	repeat (4) step(op_idle, 5'd0, 3'd0, '0, chk_none, '0);
	step(op_idle, 5'd0, 3'd0, '0, chk_timer_int, 1'b0);
	step(op_idle, 5'd0, 3'd0, '0, chk_timer_int, 1'b1);
	step(op_write, reg_compare, 3'd0, 32'h0, chk_timer_int, 1'b0);
	// ------------------------------
	exception_step(32'h0040_0104, 32'h1234_5678, exc_tlbl, 1'b1, chk_exc_level, exc_exl);
	step(op_read, reg_epc, 3'd0, '0, chk_rdata, 32'h0040_0100);
	step(op_read, reg_cause, 3'd0, '0, chk_rdata, 32'h8000_0008);
	step(op_read, reg_bad_vaddr, 3'd0, '0, chk_rdata, 32'h1234_5678);
	step(op_read, reg_entry_hi, 3'd0, '0, chk_rdata, 32'h1234_4000);
	exception_step(32'h0040_0200, 32'h0, exc_sys, 1'b0, chk_exc_level, exc_exl);
	step(op_idle, 5'd0, 3'd0, '0, chk_epc, 32'h0040_0100);
	step(op_eret, 5'd0, 3'd0, '0, chk_exc_level, exc_normal);
	// ------------------------------
	tlb_read_step(entry, chk_tlb_wentry, entry);
	step(op_read, reg_entry_lo0, 3'd0, '0, chk_rdata,
		{2'b00, 24'h65_4321, 3'd2, 1'b0, 1'b1, 1'b1});
	step(op_read, reg_entry_lo1, 3'd0, '0, chk_rdata,
		{2'b00, 24'h12_3456, 3'd3, 1'b1, 1'b1, 1'b1});
	step(op_read, reg_entry_hi, 3'd0, '0, chk_rdata, {19'h2_468a, 5'd0, 8'h5c});
	step(op_tlbp, 5'd0, 3'd0, 32'h8000_0007, chk_none, '0);
	step(op_read, reg_index, 3'd0, '0, chk_rdata, 32'h8000_0007);
	step(op_tlbwr, 5'd0, 3'd0, '0, chk_none, '0);
	step(op_tlbwr, 5'd0, 3'd0, '0, chk_none, '0);
	step(op_read, reg_random, 3'd0, '0, chk_rdata, tlb_entries_num - 3);
	// ------------------------------
	step(op_write, reg_status, 3'd0, 32'h1040_0010, chk_user_mode, 1'b1);
	step(op_write, reg_status, 3'd0, 32'h1040_0000, chk_user_mode, 1'b0);
	step(op_write, reg_config, 3'd0, 32'h0000_0002, chk_kseg0, 1'b1);
	step(op_read, reg_config, 3'd0, '0, chk_rdata, 32'h8000_0082);
	step(op_write, reg_entry_hi, 3'd0, 32'h0000_20a7, chk_asid, 8'ha7);
	step(op_read, reg_entry_hi, 3'd0, '0, chk_rdata, 32'h0000_20a7);
endtask

`endif

/* tb_cp0.sv */
module tb_cp0;
	import cp0_pkg::*;

`include "tb_cp0_vectors.svh"

	logic        clk;
	logic        rst;
	logic        we;
	reg_sel_t    wsel;
	reg_addr_t   waddr;
	word_t       wdata;
	reg_addr_t   raddr;
	reg_sel_t    rsel;
	word_t       rdata;
	logic        exc_valid;
	logic        exc_eret;
	logic        exc_delayslot;
	exc_code_t   exc_code;
	word_t       exc_pc;
	word_t       exc_extra;
	logic        tlbr_req;
	tlb_entry_t  tlbr_entry;
	logic        tlbp_req;
	word_t       tlbp_result;
	logic        tlbwr_req;
	tlb_entry_t  tlb_wentry;
	logic [7:2]  interrupt_flag;
	logic [7:0]  asid;
	logic        user_mode;
	logic        kseg0_uncached;
	exc_level_e  exc_level;
	word_t       epc;
	word_t       ebase;
	logic        timer_int;

	word_t       lcg_state;
	word_t       shadow [0:255]; // software view of the registers indexed by {sel, addr}
	logic [85:0] cur_expected;
	logic        table_ready;
	int          passes;
	int          fails;

	cp0 i_dut (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ------------------------------
	// table helpers
	// ------------------------------
	task automatic step(input op_e op, input reg_addr_t addr, input reg_sel_t sel,
		input word_t data, input chk_e chk, input logic [85:0] expected);
		row_t r;
		r = '0;
		r.op = op;
		r.addr = addr;
		r.sel = sel;
		r.data = data;
		r.chk = chk;
		r.expected = expected;
		rows.push_back(r);
	endtask

	task automatic random_step(input op_e op, input reg_addr_t addr, input reg_sel_t sel,
		input word_t filter);
		row_t r;
		r = '0;
		r.op = op;
		r.addr = addr;
		r.sel = sel;
		r.data = filter;
		r.rnd = 1'b1;
		r.chk = op == op_read ? chk_rdata : chk_none;
		rows.push_back(r);
	endtask

	task automatic exception_step(input word_t pc, input word_t extra, input exc_code_t code,
		input logic ds, input chk_e chk, input logic [85:0] expected);
		row_t r;
		r = '0;
		r.op = op_except;
		r.pc = pc;
		r.extra = extra;
		r.code = code;
		r.ds = ds;
		r.chk = chk;
		r.expected = expected;
		rows.push_back(r);
	endtask

	task automatic tlb_read_step(input tlb_entry_t entry, input chk_e chk,
		input logic [85:0] expected);
		row_t r;
		r = '0;
		r.op = op_tlbr;
		r.entry = entry;
		r.chk = chk;
		r.expected = expected;
		rows.push_back(r);
	endtask

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// software-writable bits of the registers that get random data
	function automatic word_t writable_bits(input reg_addr_t addr, input reg_sel_t sel);
		case ({sel, addr})
			{3'd0, reg_index}:     return 32'h0000_000f;
			{3'd0, reg_entry_lo0}: return 32'h03ff_ffff;
			{3'd0, reg_context}:   return 32'hff80_0000;
			{3'd0, reg_status}:    return 32'h1040_ff17;
			{3'd0, reg_cause}:     return 32'h0000_0300;
			{3'd1, reg_ebase}:     return 32'h3fff_f000;
			default:               return 32'h0;
		endcase
	endfunction

	function automatic logic [85:0] observed(input chk_e chk);
		case (chk)
			chk_rdata:      return rdata;
			chk_tlb_wentry: return tlb_wentry;
			chk_exc_level:  return exc_level;
			chk_epc:        return epc;
			chk_timer_int:  return timer_int;
			chk_user_mode:  return user_mode;
			chk_kseg0:      return kseg0_uncached;
			chk_asid:       return asid;
			chk_ebase:      return ebase;
			default:        return '0;
		endcase
	endfunction

	function automatic string signal_name(input chk_e chk);
		case (chk)
			chk_rdata:      return "rdata";
			chk_tlb_wentry: return "tlb_wentry";
			chk_exc_level:  return "exc_level";
			chk_epc:        return "epc";
			chk_timer_int:  return "timer_int";
			chk_user_mode:  return "user_mode";
			chk_kseg0:      return "kseg0_uncached";
			chk_asid:       return "asid";
			chk_ebase:      return "ebase";
			default:        return "none";
		endcase
	endfunction

	function automatic string op_name(input op_e op);
		case (op)
			op_write:  return "write";
			op_read:   return "read";
			op_except: return "except";
			op_eret:   return "eret";
			op_tlbr:   return "tlbr";
			op_tlbp:   return "tlbp";
			op_tlbwr:  return "tlbwr";
			default:   return "idle";
		endcase
	endfunction

	// ------------------------------
	// drive and check
	// ------------------------------
	task automatic clear_inputs();
		we = 1'b0;
		wsel = '0;
		waddr = '0;
		wdata = '0;
		raddr = '0;
		rsel = '0;
		exc_valid = 1'b0;
		exc_eret = 1'b0;
		exc_delayslot = 1'b0;
		exc_code = '0;
		exc_pc = '0;
		exc_extra = '0;
		tlbr_req = 1'b0;
		tlbr_entry = '0;
		tlbp_req = 1'b0;
		tlbp_result = '0;
		tlbwr_req = 1'b0;
		interrupt_flag = '0;
	endtask

	task automatic apply_row(input int i);
		row_t  r;
		word_t data;
		word_t mask;
		int    slot;
		r = rows[i];
		slot = {r.sel, r.addr};
		data = r.data;
		mask = writable_bits(r.addr, r.sel);
		cur_expected = r.expected;
		if (r.rnd && r.op == op_write) begin
			data = lcg_next() & r.data;
			shadow[slot] = (data & mask) | (shadow[slot] & ~mask);
		end else if (r.rnd && r.op == op_read) begin
			cur_expected = shadow[slot];
		end
		we = r.op == op_write;
		wsel = r.sel;
		waddr = r.addr;
		wdata = data;
		raddr = r.addr;
		rsel = r.sel;
		exc_valid = r.op == op_except || r.op == op_eret;
		exc_eret = r.op == op_eret;
		exc_delayslot = r.ds;
		exc_code = r.code;
		exc_pc = r.pc;
		exc_extra = r.extra;
		tlbr_req = r.op == op_tlbr;
		tlbr_entry = r.entry;
		tlbp_req = r.op == op_tlbp;
		tlbp_result = r.data;
		tlbwr_req = r.op == op_tlbwr;
	endtask

	task automatic check_row(input int i);
		row_t        r;
		logic [85:0] got;
		r = rows[i];
		got = observed(r.chk);
		if (r.chk == chk_none) begin
			$display("row %0d %s done", i, op_name(r.op));
		end else begin
			assert (got == cur_expected) begin
				passes++;
				$display("row %0d %s %s ok", i, op_name(r.op), signal_name(r.chk));
			end else begin
				fails++;
				$display("[ERROR] row %0d %s got %0h expected %0h", i, signal_name(r.chk),
					got, cur_expected);
			end
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		clear_inputs();
		rst = 1'b1;
		table_ready = 1'b0;
		passes = 0;
		fails = 0;
		lcg_state = 32'ha306_9a8c;
		for (int k = 0; k < 256; k++) begin
			shadow[k] = '0;
		end
		shadow[{3'd0, reg_status}] = 32'h1040_0000;
		shadow[{3'd1, reg_ebase}] = 32'h8000_0000;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(i);
			@(posedge clk);
			#1;
			check_row(i); // results of row i are settled one unit after the edge
			#1;
		end
		clear_inputs();
		$display("rows %0d, checks passed %0d, failed %0d", rows.size(), passes, fails);
		if (fails == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		wait (table_ready === 1'b1);
		#((rows.size() + 16 + 20) * 40);
		$display("watchdog expired before the vector table was finished");
		$display("Test failed");
		$finish;
	end

endmodule

/* cp0.sv */
module cp0 (
	input  logic                clk,
	input  logic                rst,

	input  logic                we,
	input  cp0_pkg::reg_sel_t   wsel,
	input  cp0_pkg::reg_addr_t  waddr,
	input  cp0_pkg::word_t      wdata,

	input  cp0_pkg::reg_addr_t  raddr,
	input  cp0_pkg::reg_sel_t   rsel,
	output cp0_pkg::word_t      rdata,

	input  logic                exc_valid,
	input  logic                exc_eret,
	input  logic                exc_delayslot,
	input  cp0_pkg::exc_code_t  exc_code,
	input  cp0_pkg::word_t      exc_pc,
	input  cp0_pkg::word_t      exc_extra,

	input  logic                tlbr_req,
	input  cp0_pkg::tlb_entry_t tlbr_entry,
	input  logic                tlbp_req,
	input  cp0_pkg::word_t      tlbp_result,
	input  logic                tlbwr_req,
	output cp0_pkg::tlb_entry_t tlb_wentry,

	input  logic [7:2]          interrupt_flag,

	output logic [7:0]          asid,
	output logic                user_mode,
	output logic                kseg0_uncached,
	output cp0_pkg::exc_level_e exc_level,
	output cp0_pkg::word_t      epc,
	output cp0_pkg::word_t      ebase,
	output logic                timer_int
);
	import cp0_pkg::*;

	word_t       wmask;
	word_t       count, compare;
	word_t       status, cause, error_epc, bad_vaddr;
	word_t       index, random, entry_lo0, entry_lo1, context_reg;
	word_t       page_mask, wired, entry_hi;
	word_t       config0;
	logic        tlb_fault_load;
	logic [18:0] fault_vpn2;
	logic [2:0]  k0;

	cp0_write_mask i_write_mask (.wsel, .waddr, .wmask);

	cp0_timer i_timer (.clk, .rst, .we, .wsel, .waddr, .wdata, .count, .compare, .timer_int);

	cp0_exc_ctrl i_exc_ctrl (
		.clk, .rst, .we, .wsel, .waddr, .wdata, .wmask,
		.exc_valid, .exc_eret, .exc_delayslot, .exc_code, .exc_pc, .exc_extra,
		.interrupt_flag,
		.status, .cause, .epc, .error_epc, .bad_vaddr, .ebase,
		.exc_level, .tlb_fault_load, .fault_vpn2
	);

	cp0_tlb_regs i_tlb_regs (
		.clk, .rst, .we, .wsel, .waddr, .wdata, .wmask,
		.tlbr_req, .tlbr_entry, .tlbp_req, .tlbp_result, .tlbwr_req,
		.tlb_fault_load, .fault_vpn2,
		.index, .random, .entry_lo0, .entry_lo1, .context_reg,
		.page_mask, .wired, .entry_hi, .tlb_wentry
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			k0 <= k0_reset;
		end else if (we && wsel == 3'd0 && waddr == reg_config) begin
			k0 <= (wdata[2:0] & wmask[2:0]) | (k0 & ~wmask[2:0]);
		end
	end

	assign config0 = {1'b1, 15'd0, 1'b0, 2'd0, 3'd0, 3'd1, 4'd0, k0}; // M set, standard TLB

	// ------------------------------
	// MFC0 read port
	// ------------------------------
	always_comb begin
		rdata = '0;
		if (rsel == 3'd0) begin
			case (raddr)
				reg_index:     rdata = index;
				reg_random:    rdata = random;
				reg_entry_lo0: rdata = entry_lo0;
				reg_entry_lo1: rdata = entry_lo1;
				reg_context:   rdata = context_reg;
				reg_page_mask: rdata = page_mask;
				reg_wired:     rdata = wired;
				reg_bad_vaddr: rdata = bad_vaddr;
				reg_count:     rdata = count;
				reg_entry_hi:  rdata = entry_hi;
				reg_compare:   rdata = compare;
				reg_status:    rdata = status;
				reg_cause:     rdata = cause;
				reg_epc:       rdata = epc;
				reg_prid:      rdata = prid_value;
				reg_config:    rdata = config0;
				reg_error_epc: rdata = error_epc;
				default:       rdata = '0;
			endcase
		end else if (rsel == 3'd1) begin
			case (raddr)
				reg_ebase:   rdata = ebase;
				reg_config1: rdata = config1_value;
				default:     rdata = '0;
			endcase
		end
	end

	assign asid           = entry_hi[7:0];
	assign user_mode      = status[4:1] == 4'b1000; // UM set with ERL, EXL clear
	assign kseg0_uncached = k0 == 3'd2;

endmodule

/* cp0_tlb_regs.sv */
module cp0_tlb_regs (
	input  logic                clk,
	input  logic                rst,
	input  logic                we,
	input  cp0_pkg::reg_sel_t   wsel,
	input  cp0_pkg::reg_addr_t  waddr,
	input  cp0_pkg::word_t      wdata,
	input  cp0_pkg::word_t      wmask,
	input  logic                tlbr_req,
	input  cp0_pkg::tlb_entry_t tlbr_entry,
	input  logic                tlbp_req,
	input  cp0_pkg::word_t      tlbp_result,
	input  logic                tlbwr_req,
	input  logic                tlb_fault_load,
	input  logic [18:0]         fault_vpn2,
	output cp0_pkg::word_t      index,
	output cp0_pkg::word_t      random,
	output cp0_pkg::word_t      entry_lo0,
	output cp0_pkg::word_t      entry_lo1,
	output cp0_pkg::word_t      context_reg,
	output cp0_pkg::word_t      page_mask,
	output cp0_pkg::word_t      wired,
	output cp0_pkg::word_t      entry_hi,
	output cp0_pkg::tlb_entry_t tlb_wentry
);
	import cp0_pkg::*;

	logic                   sel0_we;
	logic [tlb_index_w-1:0] random_q;
	logic                   g_bit;
	word_t                  lo0_read;
	word_t                  lo1_read;
	word_t                  hi_read;

	assign sel0_we = we && wsel == 3'd0;

	// ------------------------------
	// TLBR unpacking
	// ------------------------------
	assign g_bit    = tlbr_entry[tlb_g_bit];
	assign lo0_read = {2'b0, tlbr_entry[tlb_pfn0_lsb +: tlb_pfn_w],
		tlbr_entry[tlb_c0_lsb +: tlb_c_w], tlbr_entry[tlb_d0_bit],
		tlbr_entry[tlb_v0_bit], g_bit};
	assign lo1_read = {2'b0, tlbr_entry[tlb_pfn1_lsb +: tlb_pfn_w],
		tlbr_entry[tlb_c1_lsb +: tlb_c_w], tlbr_entry[tlb_d1_bit],
		tlbr_entry[tlb_v1_bit], g_bit};
	assign hi_read  = {tlbr_entry[tlb_vpn2_lsb +: tlb_vpn2_w], 5'b0,
		tlbr_entry[tlb_asid_lsb +: tlb_asid_w]};

	always_ff @(posedge clk) begin
		if (rst) begin
			index <= '0;
		end else if (tlbp_req) begin
			index <= tlbp_result; // probe result includes the P bit
		end else if (sel0_we && waddr == reg_index) begin
			index <= masked_merge(index, wdata, wmask);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			random_q <= tlb_index_w'(tlb_entries_num - 1);
		end else if (tlbwr_req) begin
			if (random_q == '0) begin
				random_q <= tlb_index_w'(tlb_entries_num - 1);
			end else begin
				random_q <= random_q - 1'b1;
			end
		end
	end

	assign random = word_t'(random_q);

	always_ff @(posedge clk) begin
		if (rst) begin
			entry_lo0   <= '0;
			entry_lo1   <= '0;
			entry_hi    <= '0;
			context_reg <= '0;
		end else begin
			if (sel0_we && waddr == reg_entry_lo0) begin
				entry_lo0 <= masked_merge(entry_lo0, wdata, wmask);
			end
			if (sel0_we && waddr == reg_entry_lo1) begin
				entry_lo1 <= masked_merge(entry_lo1, wdata, wmask);
			end
			if (sel0_we && waddr == reg_entry_hi) begin
				entry_hi <= masked_merge(entry_hi, wdata, wmask);
			end
			if (sel0_we && waddr == reg_context) begin
				context_reg <= masked_merge(context_reg, wdata, wmask);
			end
			if (tlbr_req) begin
				entry_lo0 <= lo0_read;
				entry_lo1 <= lo1_read;
				entry_hi  <= hi_read;
			end
			if (tlb_fault_load) begin
				entry_hi[31:13]   <= fault_vpn2;
				context_reg[22:4] <= fault_vpn2; // BadVPN2
			end
		end
	end

	assign page_mask = '0; // 4 KiB pages only

	always_ff @(posedge clk) begin
		if (rst) begin
			wired <= '0;
		end else if (sel0_we && waddr == reg_wired) begin
			wired <= masked_merge(wired, wdata, wmask);
		end
	end

	// ------------------------------
	// entry for TLBWI/TLBWR
	// ------------------------------
	always_comb begin
		tlb_wentry = '0;
		tlb_wentry[tlb_vpn2_lsb +: tlb_vpn2_w] = entry_hi[31:13];
		tlb_wentry[tlb_asid_lsb +: tlb_asid_w] = entry_hi[7:0];
		tlb_wentry[tlb_pfn1_lsb +: tlb_pfn_w]  = entry_lo1[29:6];
		tlb_wentry[tlb_c1_lsb +: tlb_c_w]      = entry_lo1[5:3];
		tlb_wentry[tlb_d1_bit]                 = entry_lo1[2];
		tlb_wentry[tlb_v1_bit]                 = entry_lo1[1];
		tlb_wentry[tlb_pfn0_lsb +: tlb_pfn_w]  = entry_lo0[29:6];
		tlb_wentry[tlb_c0_lsb +: tlb_c_w]      = entry_lo0[5:3];
		tlb_wentry[tlb_d0_bit]                 = entry_lo0[2];
		tlb_wentry[tlb_v0_bit]                 = entry_lo0[1];
		tlb_wentry[tlb_g_bit]                  = entry_lo0[0];
	end

	a_tlb_read_probe_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(tlbr_req && tlbp_req)
	);

endmodule

/* cp0_exc_ctrl.sv */
module cp0_exc_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                we,
	input  cp0_pkg::reg_sel_t   wsel,
	input  cp0_pkg::reg_addr_t  waddr,
	input  cp0_pkg::word_t      wdata,
	input  cp0_pkg::word_t      wmask,
	input  logic                exc_valid,
	input  logic                exc_eret,
	input  logic                exc_delayslot,
	input  cp0_pkg::exc_code_t  exc_code,
	input  cp0_pkg::word_t      exc_pc,
	input  cp0_pkg::word_t      exc_extra,
	input  logic [7:2]          interrupt_flag,
	output cp0_pkg::word_t      status,
	output cp0_pkg::word_t      cause,
	output cp0_pkg::word_t      epc,
	output cp0_pkg::word_t      error_epc,
	output cp0_pkg::word_t      bad_vaddr,
	output cp0_pkg::word_t      ebase,
	output cp0_pkg::exc_level_e exc_level,
	output logic                tlb_fault_load,
	output logic [18:0]         fault_vpn2
);
	import cp0_pkg::*;

	word_t status_q;
	word_t status_merged;
	word_t cause_next;
	logic  status_we, cause_we, epc_we, error_epc_we, ebase_we;
	logic  exc_take, eret_take;
	logic  tlb_fault, addr_fault;

	assign status_we    = we && wsel == 3'd0 && waddr == reg_status;
	assign cause_we     = we && wsel == 3'd0 && waddr == reg_cause;
	assign epc_we       = we && wsel == 3'd0 && waddr == reg_epc;
	assign error_epc_we = we && wsel == 3'd0 && waddr == reg_error_epc;
	assign ebase_we     = we && wsel == 3'd1 && waddr == reg_ebase;

	assign exc_take   = exc_valid && !exc_eret;
	assign eret_take  = exc_valid && exc_eret;
	assign tlb_fault  = exc_code == exc_tlbl || exc_code == exc_tlbs;
	assign addr_fault = tlb_fault || exc_code == exc_adel || exc_code == exc_ades;

	assign tlb_fault_load = exc_take && tlb_fault; // same cycle, so EntryHi lands with EPC
	assign fault_vpn2     = exc_extra[31:13];

	assign status_merged = masked_merge(status_q, wdata, wmask);

	// ------------------------------
	// exception level FSM
	// ------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			exc_level <= exc_normal;
		end else if (exc_take) begin
			if (exc_level != exc_erl) begin
				exc_level <= exc_exl;
			end
		end else if (eret_take) begin
			exc_level <= exc_normal; // leaves ERL first, EXL otherwise
		end else if (status_we) begin
			if (status_merged[2]) begin
				exc_level <= exc_erl;
			end else if (status_merged[1]) begin
				exc_level <= exc_exl;
			end else begin
				exc_level <= exc_normal;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			status_q <= status_reset;
		end else if (status_we) begin
			status_q <= status_merged;
		end
	end

	// EXL and ERL always reflect the FSM
	always_comb begin
		status    = status_q;
		status[2] = exc_level == exc_erl;
		status[1] = exc_level == exc_exl;
	end

	always_comb begin
		cause_next = cause;
		cause_next[15:10] = interrupt_flag;
		if (cause_we) begin
			cause_next = masked_merge(cause_next, wdata, wmask);
		end
		if (exc_take) begin
			cause_next[6:2] = exc_code;
			if (exc_level == exc_normal) begin
				cause_next[31] = exc_delayslot;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cause <= '0;
			ebase <= ebase_reset;
		end else begin
			cause <= cause_next;
			if (ebase_we) begin
				ebase <= masked_merge(ebase, wdata, wmask);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (exc_take && exc_level == exc_normal) begin
			epc <= exc_delayslot ? exc_pc - 32'd4 : exc_pc;
		end else if (epc_we) begin
			epc <= masked_merge(epc, wdata, wmask);
		end
		if (error_epc_we) begin
			error_epc <= masked_merge(error_epc, wdata, wmask);
		end
		if (exc_take && addr_fault) begin
			bad_vaddr <= exc_extra;
		end
	end

	// MEM-stage exceptions and WB-stage MTC0 to Status must be serialized by the pipeline
	a_no_exc_with_status_write: assert property (
		@(posedge clk) disable iff (rst)
		!(exc_valid && status_we)
	);

endmodule

/* cp0_timer.sv */
module cp0_timer (
	input  logic               clk,
	input  logic               rst,
	input  logic               we,
	input  cp0_pkg::reg_sel_t  wsel,
	input  cp0_pkg::reg_addr_t waddr,
	input  cp0_pkg::word_t     wdata,
	output cp0_pkg::word_t     count,
	output cp0_pkg::word_t     compare,
	output logic               timer_int
);
	import cp0_pkg::*;

	logic count_we;
	logic compare_we;
	logic match;

	assign count_we   = we && wsel == 3'd0 && waddr == reg_count;
	assign compare_we = we && wsel == 3'd0 && waddr == reg_compare;
	assign match      = compare != '0 && count == compare;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (count_we) begin
			count <= wdata; // software load wins over the increment
		end else begin
			count <= count + 32'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			compare <= '0;
		end else if (compare_we) begin
			compare <= wdata;
		end
	end

	// interrupt stays up until software acknowledges it through Compare
	always_ff @(posedge clk) begin
		if (rst) begin
			timer_int <= 1'b0;
		end else if (compare_we) begin
			timer_int <= 1'b0;
		end else if (match) begin
			timer_int <= 1'b1;
		end
	end

	a_no_int_on_zero_compare: assert property (
		@(posedge clk) disable iff (rst)
		$rose(timer_int) |-> $past(compare) != '0
	);

endmodule

/* cp0_write_mask.sv */
module cp0_write_mask (
	input  cp0_pkg::reg_sel_t  wsel,
	input  cp0_pkg::reg_addr_t waddr,
	output cp0_pkg::word_t     wmask
);
	import cp0_pkg::*;

	always_comb begin
		wmask = '0;
		if (wsel == 3'd0) begin
			case (waddr)
				reg_index, reg_wired: begin
					wmask = word_t'((1 << tlb_index_w) - 1);
				end
				reg_entry_lo0, reg_entry_lo1: begin
					wmask = 32'h03ff_ffff;
				end
				reg_context: begin
					wmask = 32'hff80_0000; // PTEBase only
				end
				reg_count, reg_compare, reg_epc, reg_error_epc: begin
					wmask = '1;
				end
				reg_entry_hi: begin
					wmask = 32'hffff_e0ff; // vpn2 and asid
				end
				reg_status: begin
					wmask = 32'h1040_ff17; // CU0 BEV IM UM ERL EXL IE
				end
				reg_cause: begin
					wmask = 32'h0000_0300; // the two software interrupt bits
				end
				reg_config: begin
					wmask = 32'h0000_0007;
				end
				default: begin
					wmask = '0;
				end
			endcase
		end else if (wsel == 3'd1 && waddr == reg_ebase) begin
			wmask = 32'h3fff_f000;
		end
	end

endmodule

/* cp0_pkg.sv */
package cp0_pkg;

	// ------------------------------
	// types
	// ------------------------------
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [2:0]  reg_sel_t;
	typedef logic [4:0]  exc_code_t;
	typedef logic [85:0] tlb_entry_t;

	typedef enum logic [1:0] {
		exc_normal,
		exc_exl,
		exc_erl
	} exc_level_e;

	// field positions inside tlb_entry_t, msb first: vpn2 asid pfn1 c1 d1 v1 pfn0 c0 d0 v0 g
	localparam int tlb_vpn2_lsb = 67;
	localparam int tlb_asid_lsb = 59;
	localparam int tlb_pfn1_lsb = 35;
	localparam int tlb_c1_lsb   = 32;
	localparam int tlb_d1_bit   = 31;
	localparam int tlb_v1_bit   = 30;
	localparam int tlb_pfn0_lsb = 6;
	localparam int tlb_c0_lsb   = 3;
	localparam int tlb_d0_bit   = 2;
	localparam int tlb_v0_bit   = 1;
	localparam int tlb_g_bit    = 0;
	localparam int tlb_vpn2_w   = 19;
	localparam int tlb_asid_w   = 8;
	localparam int tlb_pfn_w    = 24;
	localparam int tlb_c_w      = 3;

	// ------------------------------
	// register numbers
	// ------------------------------
	localparam reg_addr_t reg_index     = 5'd0;
	localparam reg_addr_t reg_random    = 5'd1;
	localparam reg_addr_t reg_entry_lo0 = 5'd2;
	localparam reg_addr_t reg_entry_lo1 = 5'd3;
	localparam reg_addr_t reg_context   = 5'd4;
	localparam reg_addr_t reg_page_mask = 5'd5;
	localparam reg_addr_t reg_wired     = 5'd6;
	localparam reg_addr_t reg_bad_vaddr = 5'd8;
	localparam reg_addr_t reg_count     = 5'd9;
	localparam reg_addr_t reg_entry_hi  = 5'd10;
	localparam reg_addr_t reg_compare   = 5'd11;
	localparam reg_addr_t reg_status    = 5'd12;
	localparam reg_addr_t reg_cause     = 5'd13;
	localparam reg_addr_t reg_epc       = 5'd14;
	localparam reg_addr_t reg_prid      = 5'd15;
	localparam reg_addr_t reg_ebase     = 5'd15; // sel 1
	localparam reg_addr_t reg_config    = 5'd16;
	localparam reg_addr_t reg_config1   = 5'd16; // sel 1
	localparam reg_addr_t reg_error_epc = 5'd30;

	localparam exc_code_t exc_int  = 5'd0;
	localparam exc_code_t exc_mod  = 5'd1;
	localparam exc_code_t exc_tlbl = 5'd2;
	localparam exc_code_t exc_tlbs = 5'd3;
	localparam exc_code_t exc_adel = 5'd4;
	localparam exc_code_t exc_ades = 5'd5;
	localparam exc_code_t exc_sys  = 5'd8;
	localparam exc_code_t exc_bp   = 5'd9;
	localparam exc_code_t exc_ri   = 5'd10;
	localparam exc_code_t exc_ov   = 5'd12;

	localparam int tlb_entries_num = 16;
	localparam int tlb_index_w     = $clog2(tlb_entries_num);

	// ------------------------------
	// cache geometry and fixed values
	// ------------------------------
	localparam int icache_size   = 8192; // bytes
	localparam int icache_assoc  = 2;
	localparam int icache_line_w = 256;  // bits per line
	localparam int dcache_size   = 8192;
	localparam int dcache_assoc  = 2;
	localparam int dcache_line_w = 256;

	localparam int ic_sets_enc  = $clog2(icache_size * 8 / icache_assoc / icache_line_w / 64);
	localparam int ic_line_enc  = $clog2(icache_line_w / 8) - 1;
	localparam int ic_assoc_enc = icache_assoc - 1;
	localparam int dc_sets_enc  = $clog2(dcache_size * 8 / dcache_assoc / dcache_line_w / 64);
	localparam int dc_line_enc  = $clog2(dcache_line_w / 8) - 1;
	localparam int dc_assoc_enc = dcache_assoc - 1;

	localparam word_t status_reset = 32'h1040_0000; // CU0 and BEV
	localparam word_t ebase_reset  = 32'h8000_0000;
	localparam logic [2:0] k0_reset = 3'd3;         // cacheable
	localparam word_t prid_value   = 32'h0001_8000;
	localparam word_t config1_value = word_t'(
		(tlb_entries_num - 1) << 25 |
		ic_sets_enc << 22 | ic_line_enc << 19 | ic_assoc_enc << 16 |
		dc_sets_enc << 13 | dc_line_enc << 10 | dc_assoc_enc << 7);

	function automatic word_t masked_merge(word_t old_val, word_t new_val, word_t mask);
		return (new_val & mask) | (old_val & ~mask);
	endfunction

endpackage
